// File: list.f
logic/board_pkg.sv
logic/uart_pkg.sv
logic/reset_pulse_gen.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/byte_fifo.sv
logic/fpga_wrapper.sv
verification/tb_fpga_wrapper.sv

// File: logic/board_pkg.sv
`default_nettype none

package board_pkg;

   // nominal board clock, 100 MHz
   localparam int unsigned CLK_PERIOD_NS = 10;

   // cycles from reset release to the start of the internal pulse
   localparam int unsigned RST_START = 5;

   // length of the internal reset pulse in cycles
   localparam int unsigned RST_DURATION = 10;

endpackage : board_pkg

`default_nettype wire

// File: logic/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo
   import uart_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              wr_i,
   input  logic [DATA_W-1:0] wdata_i,
   input  logic              rd_i,
   output logic [DATA_W-1:0] rdata_o,
   output logic              full_o,
   output logic              empty_o
);

   logic [DATA_W-1:0] mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0] wptr;
   logic [FIFO_AW-1:0] rptr;
   logic [FIFO_AW:0] count;
   logic do_wr;
   logic do_rd;

   assign full_o  = count == FIFO_DEPTH;
   assign empty_o = count == 0;

   // writes while full are dropped here
   assign do_wr = wr_i && !full_o;
   assign do_rd = rd_i && !empty_o;

   always_ff @(posedge clk_i) begin
      if (do_wr) begin
         mem[wptr] <= wdata_i;
      end
   end

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else begin
         if (do_wr) begin
            wptr <= wptr + 1'b1;
         end
         if (do_rd) begin
            rptr <= rptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // head entry, no read latency
   assign rdata_o = mem[rptr];

endmodule : byte_fifo

`default_nettype wire

// File: logic/fpga_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module fpga_wrapper
   import uart_pkg::*;
(
   input  logic clk_i,
   input  logic rst_i,
   input  logic rxd_i,
   input  logic cts_i,
   output logic txd_o,
   output logic overrun_o,
   output logic frame_err_o
);

   logic core_rst;
   logic [DATA_W-1:0] rx_data;
   logic rx_valid;
   logic rx_frame_err;
   logic [DATA_W-1:0] fifo_rdata;
   logic fifo_full;
   logic fifo_empty;
   logic tx_take;

   // stretched internal reset
   reset_pulse_gen u_reset (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .rst_o (core_rst)
   );

   uart_rx u_rx (
      .clk_i       (clk_i),
      .rst_i       (core_rst),
      .rxd_i       (rxd_i),
      .data_o      (rx_data),
      .valid_o     (rx_valid),
      .frame_err_o (rx_frame_err)
   );

   // echo buffer, full check on write is inside the FIFO
   byte_fifo u_fifo (
      .clk_i   (clk_i),
      .rst_i   (core_rst),
      .wr_i    (rx_valid),
      .wdata_i (rx_data),
      .rd_i    (tx_take),
      .rdata_o (fifo_rdata),
      .full_o  (fifo_full),
      .empty_o (fifo_empty)
   );

   uart_tx u_tx (
      .clk_i   (clk_i),
      .rst_i   (core_rst),
      .data_i  (fifo_rdata),
      .avail_i (!fifo_empty),
      .cts_i   (cts_i),
      .take_o  (tx_take),
      .txd_o   (txd_o)
   );

   // sticky status until the next reset
   always_ff @(posedge clk_i) begin
      if (core_rst) begin
         overrun_o   <= 1'b0;
         frame_err_o <= 1'b0;
      end else begin
         if (rx_valid && fifo_full) begin
            overrun_o <= 1'b1;
         end
         if (rx_frame_err) begin
            frame_err_o <= 1'b1;
         end
      end
   end

endmodule : fpga_wrapper

`default_nettype wire

// File: logic/reset_pulse_gen.sv
`timescale 1ns/1ps
`default_nettype none

module reset_pulse_gen
   import board_pkg::*;
(
   input  logic clk_i,
   input  logic rst_i,
   output logic rst_o
);

   logic rst_meta;
   logic rst_sync;
   logic [$clog2(RST_START + RST_DURATION + 1)-1:0] cnt;
   logic in_delay;
   logic in_pulse;

   // two-flop synchronizer on the board reset
   always_ff @(posedge clk_i) begin
      rst_meta <= rst_i;
      rst_sync <= rst_meta;
   end

   // start delay, then the pulse proper
   assign in_delay = cnt < RST_START;
   assign in_pulse = (cnt >= RST_START) && (cnt < RST_START + RST_DURATION);

   // counter saturates once the pulse has ended
   always_ff @(posedge clk_i) begin
      if (rst_sync) begin
         cnt <= '0;
      end else if (in_delay || in_pulse) begin
         cnt <= cnt + 1'b1;
      end
   end

   // internal reset covers the board reset, the delay and the pulse
   always_ff @(posedge clk_i) begin
      if (rst_sync) begin
         rst_o <= 1'b1;
      end else begin
         rst_o <= in_delay | in_pulse;
      end
   end

endmodule : reset_pulse_gen

`default_nettype wire

// File: logic/uart_pkg.sv
`default_nettype none

package uart_pkg;

   // clock cycles per serial bit
   localparam int unsigned BAUD_DIV = 16;

   // bits per character
   localparam int unsigned DATA_W = 8;

   // echo buffer geometry, depth must be a power of two
   localparam int unsigned FIFO_DEPTH = 8;
   localparam int unsigned FIFO_AW = 3;

   // receiver FSM
   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   // transmitter FSM
   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

endpackage : uart_pkg

`default_nettype wire

// File: logic/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx
   import uart_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              rxd_i,
   output logic [DATA_W-1:0] data_o,
   output logic              valid_o,
   output logic              frame_err_o
);

   rx_state_t state;
   logic rxd_meta;
   logic rxd_sync;
   logic rxd_prev;
   logic [$clog2(BAUD_DIV)-1:0] cnt;
   logic [$clog2(DATA_W)-1:0] bit_idx;
   logic [DATA_W-1:0] shift;

   // line idles high, so the synchronizer resets to one
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end else begin
         rxd_meta <= rxd_i;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state       <= RX_IDLE;
         cnt         <= '0;
         bit_idx     <= '0;
         valid_o     <= 1'b0;
         frame_err_o <= 1'b0;
      end else begin
         valid_o     <= 1'b0;
         frame_err_o <= 1'b0;
         case (state)
            RX_IDLE: begin
               // falling edge only, a line stuck low after a bad stop bit
               // does not start another frame
               cnt <= '0;
               if (rxd_prev && !rxd_sync) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               if (cnt == BAUD_DIV / 2 - 1) begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  // glitch if the line is already back high
                  state   <= rxd_sync ? RX_IDLE : RX_DATA;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (cnt == BAUD_DIV - 1) begin
                  cnt <= '0;
                  if (bit_idx == DATA_W - 1) begin
                     state <= RX_STOP;
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                  end
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_STOP: begin
               if (cnt == BAUD_DIV - 1) begin
                  cnt         <= '0;
                  state       <= RX_IDLE;
                  valid_o     <= rxd_sync;
                  frame_err_o <= !rxd_sync;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // lsb first, sampled at bit centers
   always_ff @(posedge clk_i) begin
      if (state == RX_DATA && cnt == BAUD_DIV - 1) begin
         shift <= {rxd_sync, shift[DATA_W-1:1]};
      end
   end

   assign data_o = shift;

endmodule : uart_rx

`default_nettype wire

// File: logic/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx
   import uart_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic [DATA_W-1:0] data_i,
   input  logic              avail_i,
   input  logic              cts_i,
   output logic              take_o,
   output logic              txd_o
);

   tx_state_t state;
   logic [$clog2(BAUD_DIV)-1:0] cnt;
   logic [$clog2(DATA_W)-1:0] bit_idx;
   logic [DATA_W-1:0] shift;
   logic bit_end;

   // new frame only from idle with clear-to-send
   assign take_o  = (state == TX_IDLE) && avail_i && cts_i;
   assign bit_end = cnt == BAUD_DIV - 1;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
         txd_o   <= 1'b1;
      end else begin
         cnt <= bit_end ? '0 : cnt + 1'b1;
         case (state)
            TX_IDLE: begin
               cnt   <= '0;
               txd_o <= 1'b1;
               if (take_o) begin
                  state <= TX_START;
                  txd_o <= 1'b0;
               end
            end
            TX_START: begin
               if (bit_end) begin
                  state   <= TX_DATA;
                  bit_idx <= '0;
                  txd_o   <= shift[0];
               end
            end
            TX_DATA: begin
               if (bit_end) begin
                  if (bit_idx == DATA_W - 1) begin
                     state <= TX_STOP;
                     txd_o <= 1'b1;
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                     txd_o   <= shift[1];
                  end
               end
            end
            TX_STOP: begin
               if (bit_end) begin
                  state <= TX_IDLE;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   // head byte loaded on take, shifted right after each data bit
   always_ff @(posedge clk_i) begin
      if (take_o) begin
         shift <= data_i;
      end else if (state == TX_DATA && bit_end) begin
         shift <= shift >> 1;
      end
   end

endmodule : uart_tx

`default_nettype wire

// File: verification/tb_fpga_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_wrapper
   import board_pkg::*, uart_pkg::*;
();

   localparam int NUM_TESTS = 6;
   localparam int MAX_BYTES = 10;
   // wait limit for a start bit on txd_o, also the idle window
   localparam int ECHO_TIMEOUT = 30 * BAUD_DIV;

   // test kinds
   localparam int K_IDLE = 0;
   localparam int K_FRAMES = 1;
   localparam int K_GLITCH = 2;

   logic clk_i;
   logic rst_i;
   logic rxd_i;
   logic cts_i;
   logic txd_o;
   logic overrun_o;
   logic frame_err_o;

   // test table, one row per case
   string t_name [NUM_TESTS];
   int t_kind [NUM_TESTS];
   logic [7:0] t_data [NUM_TESTS][MAX_BYTES];
   int t_count [NUM_TESTS];
   logic t_cts [NUM_TESTS];
   int t_bad [NUM_TESTS];
   logic [7:0] t_exp [NUM_TESTS][MAX_BYTES];
   int t_exp_count [NUM_TESTS];
   logic t_exp_ovr [NUM_TESTS];
   logic t_exp_fe [NUM_TESTS];

   integer seed = 32'h20b7_29fc;
   int pass_count;
   int fail_count;
   int row_errs;
   bit watch_idle;
   bit low_seen;

   fpga_wrapper u_dut (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .rxd_i       (rxd_i),
      .cts_i       (cts_i),
      .txd_o       (txd_o),
      .overrun_o   (overrun_o),
      .frame_err_o (frame_err_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;
   end

   // line must stay idle while the transmitter is held off
   always @(negedge clk_i) begin
      if (watch_idle && txd_o !== 1'b1) begin
         low_seen = 1'b1;
      end
   end

   task automatic set_row(input int r, input string name, input int kind, input int count,
                          input logic cts, input int bad, input logic ovr, input logic fe);
      t_name[r]    = name;
      t_kind[r]    = kind;
      t_count[r]   = count;
      t_cts[r]     = cts;
      t_bad[r]     = bad;
      t_exp_ovr[r] = ovr;
      t_exp_fe[r]  = fe;
   endtask

   task automatic build_table();
      int n;
      for (int r = 0; r < NUM_TESTS; r++) begin
         for (int i = 0; i < MAX_BYTES; i++) begin
            t_data[r][i] = $random(seed);
         end
      end
      set_row(0, "reset idle", K_IDLE, 0, 1'b1, -1, 1'b0, 1'b0);
      set_row(1, "single echo", K_FRAMES, 1, 1'b1, -1, 1'b0, 1'b0);
      set_row(2, "ordered burst", K_FRAMES, 5, 1'b1, -1, 1'b0, 1'b0);
      set_row(3, "back-pressure", K_FRAMES, 10, 1'b0, -1, 1'b1, 1'b0);
      set_row(4, "framing error", K_FRAMES, 2, 1'b1, 0, 1'b0, 1'b1);
      set_row(5, "glitch", K_GLITCH, 0, 1'b1, -1, 1'b0, 1'b0);
      // bad frames are never echoed, a held-off FIFO keeps only the first entries
      for (int r = 0; r < NUM_TESTS; r++) begin
         n = 0;
         for (int i = 0; i < t_count[r]; i++) begin
            if (i != t_bad[r] && (t_cts[r] || n < FIFO_DEPTH)) begin
               t_exp[r][n] = t_data[r][i];
               n++;
            end
         end
         t_exp_count[r] = n;
      end
   endtask

   task automatic report_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
      $display("FAIL %s: expected %0h got %0h", name, expected, actual);
      row_errs++;
   endtask

   task automatic apply_reset();
      @(posedge clk_i);
      #1 rst_i = 1'b1;
      rxd_i = 1'b1;
      cts_i = 1'b0;
      repeat (4) @(posedge clk_i);
      #1 rst_i = 1'b0;
      // synchronizer plus the stretched internal pulse
      repeat (RST_START + RST_DURATION + 4) @(posedge clk_i);
      #1;
   endtask

   task automatic drive_bit(input logic b);
      @(posedge clk_i);
      #1 rxd_i = b;
      repeat (BAUD_DIV - 1) @(posedge clk_i);
   endtask

   task automatic send_frame(input logic [7:0] data, input bit bad_stop);
      drive_bit(1'b0);
      for (int i = 0; i < DATA_W; i++) begin
         drive_bit(data[i]);
      end
      drive_bit(!bad_stop);
      // line back high so the next start bit is an edge
      if (bad_stop) begin
         drive_bit(1'b1);
      end
   endtask

   task automatic send_all(input int r);
      if (t_kind[r] == K_FRAMES) begin
         for (int i = 0; i < t_count[r]; i++) begin
            send_frame(t_data[r][i], i == t_bad[r]);
         end
      end else if (t_kind[r] == K_GLITCH) begin
         // a quarter bit, shorter than the half-bit recheck
         @(posedge clk_i);
         #1 rxd_i = 1'b0;
         repeat (BAUD_DIV / 4) @(posedge clk_i);
         #1 rxd_i = 1'b1;
      end
   endtask

   task automatic read_frame(output logic [7:0] data, output logic stop, output bit timed_out);
      int waited;
      waited = 0;
      timed_out = 1'b0;
      data = '0;
      stop = 1'b1;
      @(posedge clk_i);
      #1;
      while (txd_o !== 1'b0 && waited < ECHO_TIMEOUT) begin
         @(posedge clk_i);
         #1;
         waited++;
      end
      if (txd_o !== 1'b0) begin
         timed_out = 1'b1;
         return;
      end
      // middle of the start bit, then one bit time per sample
      repeat (BAUD_DIV / 2) @(posedge clk_i);
      for (int i = 0; i < DATA_W; i++) begin
         repeat (BAUD_DIV) @(posedge clk_i);
         #1;
         data[i] = txd_o;
      end
      repeat (BAUD_DIV) @(posedge clk_i);
      #1;
      stop = txd_o;
   endtask

   task automatic collect(input int r);
      logic [7:0] got;
      logic stop;
      bit tmo;
      for (int i = 0; i < t_exp_count[r]; i++) begin
         read_frame(got, stop, tmo);
         if (tmo) begin
            $display("timeout waiting for echo byte %0d on txd_o", i);
            row_errs++;
            return;
         end
         if (got !== t_exp[r][i]) begin
            report_value($sformatf("txd_o byte %0d", i), t_exp[r][i], got);
         end
         if (stop !== 1'b1) begin
            report_value($sformatf("txd_o stop bit %0d", i), 8'h1, {7'b0, stop});
         end
      end
      read_frame(got, stop, tmo);
      if (!tmo) begin
         $display("unexpected extra frame on txd_o carrying %02h", got);
         row_errs++;
      end
   endtask

   task automatic run_test(input int r);
      row_errs = 0;
      apply_reset();
      if (txd_o !== 1'b1) begin
         report_value("txd_o after reset", 8'h1, {7'b0, txd_o});
      end
      if (overrun_o !== 1'b0) begin
         report_value("overrun_o after reset", 8'h0, {7'b0, overrun_o});
      end
      if (frame_err_o !== 1'b0) begin
         report_value("frame_err_o after reset", 8'h0, {7'b0, frame_err_o});
      end
      cts_i = t_cts[r];
      if (!t_cts[r]) begin
         low_seen = 1'b0;
         watch_idle = 1'b1;
         send_all(r);
         repeat (BAUD_DIV) @(posedge clk_i);
         #1 watch_idle = 1'b0;
         if (low_seen) begin
            $display("txd_o left idle while cts_i was low");
            row_errs++;
         end
         cts_i = 1'b1;
         collect(r);
      end else begin
         fork
            send_all(r);
            collect(r);
         join
      end
      if (overrun_o !== t_exp_ovr[r]) begin
         report_value("overrun_o", {7'b0, t_exp_ovr[r]}, {7'b0, overrun_o});
      end
      if (frame_err_o !== t_exp_fe[r]) begin
         report_value("frame_err_o", {7'b0, t_exp_fe[r]}, {7'b0, frame_err_o});
      end
      if (row_errs == 0) begin
         pass_count++;
         $display("test %0d %s: pass", r, t_name[r]);
      end else begin
         fail_count++;
         $display("test %0d %s: FAIL with %0d errors", r, t_name[r], row_errs);
      end
   endtask

   initial begin
      rst_i = 1'b1;
      rxd_i = 1'b1;
      cts_i = 1'b0;
      watch_idle = 1'b0;
      low_seen = 1'b0;
      pass_count = 0;
      fail_count = 0;
      row_errs = 0;
      build_table();
      for (int r = 0; r < NUM_TESTS; r++) begin
         run_test(r);
      end
      $display("passed %0d, failed %0d tests", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule : tb_fpga_wrapper

`default_nettype wire
